// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_gselect
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
src/bp_cfg_pkg.sv
src/bp_types_pkg.sv
src/resolve_if.sv
src/branch_commit_capture.sv
src/resolve_queue.sv
src/gselect_table.sv
src/gselect_predictor_top.sv
verification/tb_clock_gen.sv
verification/tb_gselect.sv

// ==== src/bp_cfg_pkg.sv ====
`default_nettype none

package bp_cfg_pkg;

	// ==============================
	// Address and table sizing
	// ==============================

	// Width of instruction addresses seen at fetch and at commit
	localparam int addr_w = 32;

	// Low address bits that select a row of counters
	localparam int pc_idx_bits = 7;
	// Number of recent outcomes kept in the global history
	localparam int hist_bits = 2;
	// The table index is the address bits with the history appended below them
	localparam int tbl_idx_w = pc_idx_bits + hist_bits;
	localparam int tbl_entries = 1 << tbl_idx_w;

	// ==============================
	// Resolve queue sizing
	// ==============================

	// Depth must stay a power of two so the pointers wrap on their own
	localparam int q_depth = 32;
	localparam int q_ptr_w = $clog2(q_depth);

endpackage

`default_nettype wire

// ==== src/bp_types_pkg.sv ====
`default_nettype none

package bp_types_pkg;

	import bp_cfg_pkg::*;

	// Two bit saturating counter
	// The upper bit alone gives the predicted direction
	typedef enum logic [1:0] {
		strong_not   = 2'd0,
		weak_not     = 2'd1,
		weak_taken   = 2'd2,
		strong_taken = 2'd3
	} ctr_e;

	// Table sequencing
	// st_clear sweeps every counter to weak_not after reset, st_run serves fetch and commit
	typedef enum logic {
		st_clear,
		st_run
	} tbl_state_e;

	// One resolved branch as it sits in the queue and reaches the table
	typedef struct packed {
		logic              taken;
		logic [addr_w-1:0] pc;
	} resolved_br_t;

endpackage

`default_nettype wire

// ==== src/branch_commit_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

// Registers the two commit slots coming from the commit stage
// Slot 0 is always the older of the two branches
module branch_commit_capture import bp_cfg_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic [1:0]        commit_valid,
	input  wire logic [1:0]        commit_taken,
	input  wire logic [addr_w-1:0] commit_pc0,
	input  wire logic [addr_w-1:0] commit_pc1,
	resolve_if.capture             res
);

	// ==============================
	// Slot filtering
	// ==============================

	// A taken branch in slot 0 redirects fetch, so nothing younger in slot 1
	// can really have committed in the same cycle
	logic slot0_redirect;
	logic slot1_keep;

	assign slot0_redirect = commit_valid[0] & commit_taken[0];
	assign slot1_keep     = commit_valid[1] & ~slot0_redirect;

	// ==============================
	// Commit register
	// ==============================

	// The valid bits hold the filtered slot 1 strobe and clear on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			res.slot_valid <= 2'b00;
		end else begin
			res.slot_valid <= {slot1_keep, commit_valid[0]};
		end
	end

	// Outcomes and addresses follow the valid bits one cycle after commit
	always_ff @(posedge clk) begin
		res.slot_taken <= commit_taken;
		res.slot_pc0   <= commit_pc0;
		res.slot_pc1   <= commit_pc1;
	end

	// The queue writes slot 1 after slot 0, so a younger slot behind a redirect
	// would train a counter with a branch that never executed
	a_no_slot1_after_taken: assert property (
		@(posedge clk) disable iff (rst)
		(res.slot_valid[0] && res.slot_taken[0]) |-> !res.slot_valid[1]
	);

endmodule

`default_nettype wire

// ==== src/gselect_predictor_top.sv ====
`timescale 1ns/100ps
`default_nettype none

// Gselect branch direction predictor
// Fetch gets a same cycle prediction, commit feeds two resolved slots per cycle
module gselect_predictor_top import bp_cfg_pkg::*, bp_types_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              en,
	input  wire logic [addr_w-1:0] ip,
	output logic                   predict_taken,
	input  wire logic [1:0]        commit_valid,
	input  wire logic [1:0]        commit_taken,
	input  wire logic [addr_w-1:0] commit_pc0,
	input  wire logic [addr_w-1:0] commit_pc1,
	output logic                   overflow,
	output logic                   ready,
	output logic                   idle
);

	// Registered commit slots between capture and queue
	resolve_if u_res ();

	// Queue head and its handshake with the table
	resolved_br_t head;
	logic         not_empty;
	logic         pop;

	branch_commit_capture u_capture (
		.clk          (clk),
		.rst          (rst),
		.commit_valid (commit_valid),
		.commit_taken (commit_taken),
		.commit_pc0   (commit_pc0),
		.commit_pc1   (commit_pc1),
		.res          (u_res.capture)
	);

	resolve_queue u_queue (
		.clk       (clk),
		.rst       (rst),
		.res       (u_res.queue),
		.head      (head),
		.not_empty (not_empty),
		.pop       (pop),
		.overflow  (overflow)
	);

	gselect_table u_table (
		.clk           (clk),
		.rst           (rst),
		.en            (en),
		.ip            (ip),
		.predict_taken (predict_taken),
		.head          (head),
		.not_empty     (not_empty),
		.pop           (pop),
		.ready         (ready)
	);

	// Nothing left to train once the sweep is done and the queue has drained
	assign idle = ready && !not_empty;

endmodule

`default_nettype wire

// ==== src/gselect_table.sv ====
`timescale 1ns/100ps
`default_nettype none

// Gselect direction table
// Each entry is a two bit counter selected by low address bits and the global history
module gselect_table import bp_cfg_pkg::*, bp_types_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              en,
	input  wire logic [addr_w-1:0] ip,
	output logic                   predict_taken,
	input  wire resolved_br_t      head,
	input  wire logic              not_empty,
	output logic                   pop,
	output logic                   ready
);

	// Counter storage that the clear sweep fills after every reset
	ctr_e tbl [tbl_entries];

	tbl_state_e           state;
	logic [tbl_idx_w-1:0] clr_idx;
	logic [hist_bits-1:0] hist;

	logic [tbl_idx_w-1:0] rd_idx;
	logic [tbl_idx_w-1:0] wr_idx;
	ctr_e                 rd_ctr;
	ctr_e                 wr_ctr;
	ctr_e                 wr_ctr_next;
	logic                 train;

	// ==============================
	// Sequencing
	// ==============================

	// After reset every counter is walked once, one entry per cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= st_clear;
			clr_idx <= '0;
		end else begin
			case (state)
				st_clear: begin
					clr_idx <= clr_idx + 1'b1;
					if (clr_idx == tbl_idx_w'(tbl_entries - 1))
						state <= st_run;
				end
				st_run: begin
					state <= st_run;
				end
				default: begin
					state <= st_clear;
				end
			endcase
		end
	end

	assign ready = (state == st_run);

	// Pop is combinational so the queue head advances on the same edge that trains
	assign pop   = ready && not_empty;
	// With en low the record is still consumed but thrown away
	assign train = pop && en;

	// ==============================
	// Training
	// ==============================

	// Index uses the history as it stands before this outcome is shifted in
	assign wr_idx = {head.pc[pc_idx_bits-1:0], hist};
	assign wr_ctr = tbl[wr_idx];

	// Saturating step toward the resolved direction
	always_comb begin
		case (wr_ctr)
			strong_not:   wr_ctr_next = head.taken ? weak_not : strong_not;
			weak_not:     wr_ctr_next = head.taken ? weak_taken : strong_not;
			weak_taken:   wr_ctr_next = head.taken ? strong_taken : weak_not;
			strong_taken: wr_ctr_next = head.taken ? strong_taken : weak_taken;
			default:      wr_ctr_next = weak_not;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == st_clear)
			tbl[clr_idx] <= weak_not;
		else if (train)
			tbl[wr_idx] <= wr_ctr_next;
	end

	// Newest outcome enters at bit 0
	always_ff @(posedge clk) begin
		if (rst) begin
			hist <= '0;
		end else if (train) begin
			hist <= {hist[hist_bits-2:0], head.taken};
		end
	end

	// ==============================
	// Prediction
	// ==============================

	// Fetch side lookup, same index layout as training
	assign rd_idx = {ip[pc_idx_bits-1:0], hist};
	assign rd_ctr = tbl[rd_idx];

	// Held low during the sweep since the table contents are not yet defined
	assign predict_taken = en && ready && rd_ctr[1];

	// A pop during the sweep would lose a record while the table is still being written
	a_pop_only_in_run: assert property (
		@(posedge clk) disable iff (rst)
		pop |-> (state == st_run)
	);

endmodule

`default_nettype wire

// ==== src/resolve_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Carries the two registered commit slots from the capture stage to the queue
// A set valid bit is a single cycle strobe and there is no handshake back
interface resolve_if import bp_cfg_pkg::*; ();

	// Bit 0 belongs to the older slot, bit 1 to the younger one
	logic [1:0]        slot_valid;
	logic [1:0]        slot_taken;
	// Branch addresses of the two slots
	logic [addr_w-1:0] slot_pc0;
	logic [addr_w-1:0] slot_pc1;

	// The capture stage drives every signal
	modport capture (
		output slot_valid,
		output slot_taken,
		output slot_pc0,
		output slot_pc1
	);

	// The queue only samples them
	modport queue (
		input slot_valid,
		input slot_taken,
		input slot_pc0,
		input slot_pc1
	);

endinterface

`default_nettype wire

// ==== src/resolve_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

// Circular queue of resolved branches
// Up to two records enter per cycle from the capture stage, one leaves per cycle
module resolve_queue import bp_cfg_pkg::*, bp_types_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst,
	resolve_if.queue   res,
	output resolved_br_t head,
	output logic       not_empty,
	input  wire logic  pop,
	output logic       overflow
);

	// Record storage addressed by the head and tail pointers
	resolved_br_t mem [q_depth];

	logic [q_ptr_w-1:0] head_ptr;
	logic [q_ptr_w-1:0] tail_ptr;
	logic [q_ptr_w-1:0] tail_ptr_p1;
	// One bit wider than the pointers so a full queue is distinct from empty
	logic [q_ptr_w:0]   count;
	logic [q_ptr_w:0]   free;

	// Records in write order for this cycle
	resolved_br_t first_rec;
	resolved_br_t second_rec;
	logic         has_first;
	logic         has_second;
	logic         acc_first;
	logic         acc_second;
	logic         drop;

	// ==============================
	// Write ordering
	// ==============================

	// When only slot 1 is valid it takes the first write position
	always_comb begin
		first_rec  = '{taken: res.slot_taken[0], pc: res.slot_pc0};
		second_rec = '{taken: res.slot_taken[1], pc: res.slot_pc1};
		has_first  = res.slot_valid[0];
		has_second = res.slot_valid[1];
		if (!res.slot_valid[0]) begin
			first_rec  = second_rec;
			has_first  = res.slot_valid[1];
			has_second = 1'b0;
		end
	end

	// Space is judged before this cycle's pop, so a full queue drops even while draining
	assign free        = (q_ptr_w + 1)'(q_depth) - count;
	assign acc_first   = has_first && (free != '0);
	assign acc_second  = has_second && (free > 1);
	assign drop        = (has_first && !acc_first) || (has_second && !acc_second);
	assign tail_ptr_p1 = tail_ptr + 1'b1;

	// ==============================
	// Pointers, count and overflow
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (pop)
				head_ptr <= head_ptr + 1'b1;
			tail_ptr <= tail_ptr + q_ptr_w'(acc_first) + q_ptr_w'(acc_second);
			count    <= count + (q_ptr_w + 1)'(acc_first) + (q_ptr_w + 1)'(acc_second)
				- (q_ptr_w + 1)'(pop);
			// Sticky until the next reset
			if (drop)
				overflow <= 1'b1;
		end
	end

	// Slot order is kept by writing the older record at the lower position
	always_ff @(posedge clk) begin
		if (acc_first)
			mem[tail_ptr] <= first_rec;
		if (acc_second)
			mem[tail_ptr_p1] <= second_rec;
	end

	assign head      = mem[head_ptr];
	assign not_empty = (count != '0);

	a_count_bounded: assert property (
		@(posedge clk) disable iff (rst)
		count <= (q_ptr_w + 1)'(q_depth)
	);

	// The table must never consume a record that was not written
	a_no_pop_when_empty: assert property (
		@(posedge clk) disable iff (rst)
		pop |-> not_empty
	);

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

// Free running 40 ns clock and a power on reset held for 8 rising edges
module tb_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Released on a rising edge so the synchronous reset sees whole cycles
	initial begin
		rst <= 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verification/tb_gselect.sv ====
`timescale 1ns/100ps
`default_nettype none

// Directed tests for the gselect predictor against an untimed reference model
module tb_gselect import bp_cfg_pkg::*; ();

	logic                 clk;
	logic                 gen_rst;
	logic                 tb_rst;
	logic                 rst;
	logic                 en;
	logic [addr_w-1:0]    ip;
	logic                 predict_taken;
	logic [1:0]           commit_valid;
	logic [1:0]           commit_taken;
	logic [addr_w-1:0]    commit_pc0;
	logic [addr_w-1:0]    commit_pc1;
	logic                 overflow;
	logic                 ready;
	logic                 idle;

	// ==============================
	// Reference model state
	// ==============================

	// Plain 2 bit counters where 1 stands for weak not taken
	logic [1:0]           m_ctr [tbl_entries];
	logic [hist_bits-1:0] m_hist;
	// Outcomes in commit order with the taken bit above the pc
	logic [addr_w:0]      m_pend [$];
	logic [addr_w-1:0]    seen_pc [$];
	logic [15:0]          lfsr = 16'd18824;

	assign rst = gen_rst | tb_rst;

	tb_clock_gen u_clk (.clk (clk), .rst (gen_rst));

	gselect_predictor_top u_dut (
		.clk (clk), .rst (rst), .en (en), .ip (ip), .predict_taken (predict_taken),
		.commit_valid (commit_valid), .commit_taken (commit_taken),
		.commit_pc0 (commit_pc0), .commit_pc1 (commit_pc1),
		.overflow (overflow), .ready (ready), .idle (idle)
	);

	// Galois LFSR stepped once per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[0];
			lfsr = {1'b0, lfsr[15:1]} ^ (fb ? 16'hB400 : 16'h0000);
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			fail_now("value mismatch");
		end
	endtask

	task automatic model_reset();
		for (int i = 0; i < tbl_entries; i++)
			m_ctr[i] = 2'd1;
		m_hist = '0;
		m_pend.delete();
	endtask

	task automatic model_commit(input logic [1:0] v, input logic [1:0] t,
			input logic [addr_w-1:0] pc0, input logic [addr_w-1:0] pc1);
		if (v[0])
			m_pend.push_back({t[0], pc0});
		// Nothing younger than a taken branch commits in the same cycle
		if (v[1] && !(v[0] && t[0]))
			m_pend.push_back({t[1], pc1});
	endtask

	// Applies every pending outcome unless en is low
	task automatic model_drain();
		logic [addr_w:0]      rec;
		logic [tbl_idx_w-1:0] idx;
		while (m_pend.size() > 0) begin
			rec = m_pend.pop_front();
			idx = {rec[pc_idx_bits-1:0], m_hist};
			if (en) begin
				if (rec[addr_w] && m_ctr[idx] != 2'd3)
					m_ctr[idx] = m_ctr[idx] + 2'd1;
				else if (!rec[addr_w] && m_ctr[idx] != 2'd0)
					m_ctr[idx] = m_ctr[idx] - 2'd1;
				m_hist = {m_hist[hist_bits-2:0], rec[addr_w]};
			end
		end
	endtask

	function automatic logic model_predict(input logic [addr_w-1:0] pc);
		logic [tbl_idx_w-1:0] idx;
		idx = {pc[pc_idx_bits-1:0], m_hist};
		return en && m_ctr[idx][1];
	endfunction

	// At most one record leaves per cycle while a burst is written
	function automatic logic expect_overflow(input int n_rec, input int n_cyc);
		return (n_rec - n_cyc) > q_depth;
	endfunction

	// ==============================
	// Stimulus and waits
	// ==============================

	task automatic drive_commit(input logic [1:0] v, input logic [1:0] t,
			input logic [addr_w-1:0] pc0, input logic [addr_w-1:0] pc1);
		@(posedge clk);
		commit_valid <= v;
		commit_taken <= t;
		commit_pc0   <= pc0;
		commit_pc1   <= pc1;
	endtask

	task automatic send_commit(input logic [1:0] v, input logic [1:0] t,
			input logic [addr_w-1:0] pc0, input logic [addr_w-1:0] pc1);
		drive_commit(v, t, pc0, pc1);
		model_commit(v, t, pc0, pc1);
	endtask

	// The sweep writes one entry per cycle, so ready stays low for the whole table
	task automatic wait_for_ready();
		int n;
		n = 0;
		@(negedge clk);
		while (ready !== 1'b1 && n < 700) begin
			check_val("predict_taken", 32'(predict_taken), 32'(1'b0));
			@(negedge clk);
			n++;
		end
		if (ready !== 1'b1)
			fail_now("timeout waiting for the table clear sweep to finish");
		else if (n < tbl_entries)
			fail_now("ready rose before the clear sweep had covered every table entry");
	endtask

	task automatic wait_for_idle();
		int n;
		n = 0;
		@(negedge clk);
		while (idle !== 1'b1 && n < 400) begin
			@(negedge clk);
			n++;
		end
		if (idle !== 1'b1)
			fail_now("timeout waiting for the resolve queue to drain");
	endtask

	// The capture and queue registers delay the drop of idle by two edges
	task automatic flush_commits(input logic busy);
		@(posedge clk);
		commit_valid <= 2'b00;
		@(posedge clk);
		@(negedge clk);
		check_val("idle", 32'(idle), 32'(!busy));
		@(posedge clk);
		wait_for_idle();
	endtask

	task automatic settle();
		flush_commits(m_pend.size() > 0);
		model_drain();
	endtask

	task automatic check_predict(input logic [addr_w-1:0] pc);
		@(posedge clk);
		ip <= pc;
		@(negedge clk);
		check_val("predict_taken", 32'(predict_taken), 32'(model_predict(pc)));
	endtask

	task automatic check_seen();
		foreach (seen_pc[i])
			check_predict(seen_pc[i]);
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic test_cleared_table();
		for (int i = 0; i < 16; i++)
			check_predict(rand_bits(32));
	endtask

	task automatic test_single_train();
		logic [addr_w-1:0] pc;
		pc = rand_bits(32);
		seen_pc.push_back(pc);
		for (int i = 0; i < 8; i++) begin
			// Four taken outcomes, then four not taken
			send_commit(2'b01, {1'b0, i < 4}, pc, '0);
			settle();
			check_predict(pc);
		end
	endtask

	task automatic test_dual_commit();
		logic [addr_w-1:0] pc0;
		logic [addr_w-1:0] pc1;
		logic [1:0]        t;
		for (int i = 0; i < 6; i++) begin
			pc0 = rand_bits(32);
			pc1 = rand_bits(32);
			t   = (i == 0) ? 2'b10 : (i == 1) ? 2'b01 : 2'(rand_bits(2));
			seen_pc.push_back(pc0);
			seen_pc.push_back(pc1);
			send_commit(2'b11, t, pc0, pc1);
			settle();
			check_predict(pc0);
			check_predict(pc1);
		end
	endtask

	task automatic test_enable_gate();
		logic [addr_w-1:0] pc;
		pc = rand_bits(32);
		seen_pc.push_back(pc);
		send_commit(2'b01, 2'b01, pc, '0);
		settle();
		@(posedge clk);
		en <= 1'b0;
		for (int i = 0; i < 3; i++) begin
			send_commit(2'b11, 2'b10, pc, pc);
			settle();
		end
		check_seen();
		@(posedge clk);
		en <= 1'b1;
		check_seen();
	endtask

	task automatic test_overflow();
		int n_rec;
		for (int i = 0; i < 8; i++)
			send_commit(2'b11, 2'(rand_bits(2)), rand_bits(32), rand_bits(32));
		n_rec = m_pend.size();
		settle();
		check_val("overflow", 32'(overflow), 32'(expect_overflow(n_rec, 8)));
		check_seen();
		// Both slots not taken, so each burst cycle offers two records
		for (int i = 0; i < 40; i++)
			drive_commit(2'b11, 2'b00, rand_bits(32), rand_bits(32));
		flush_commits(1'b1);
		check_val("overflow", 32'(overflow), 32'(expect_overflow(80, 40)));
		repeat (16) @(negedge clk);
		check_val("overflow", 32'(overflow), 32'(1'b1));
		@(posedge clk);
		tb_rst <= 1'b1;
		repeat (8) @(posedge clk);
		tb_rst <= 1'b0;
		model_reset();
		wait_for_ready();
		check_val("overflow", 32'(overflow), 32'(1'b0));
		check_seen();
	endtask

	initial begin
		en           <= 1'b1;
		ip           <= '0;
		commit_valid <= 2'b00;
		commit_taken <= 2'b00;
		commit_pc0   <= '0;
		commit_pc1   <= '0;
		tb_rst       <= 1'b0;
		model_reset();
		wait_for_ready();
		test_cleared_table();
		test_single_train();
		test_dual_commit();
		test_enable_gate();
		test_overflow();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire
